/* source/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// ------------------------------------------------
	// Cache geometry
	localparam int ADDR_W         = 32;
	localparam int DATA_W         = 32;
	localparam int BYTES_PER_WORD = DATA_W / 8;
	localparam int LINE_WORDS     = 4;
	localparam int NUM_LINES      = 64;
	localparam int BYTE_OFS_W     = 2;
	localparam int WORD_OFS_W     = 2;
	localparam int INDEX_W        = 6;
	localparam int TAG_W          = ADDR_W - INDEX_W - WORD_OFS_W - BYTE_OFS_W;

	// Size code of a full-width transfer
	localparam logic [2:0] HSIZE_WORD = 3'd2;

	// ------------------------------------------------
	// Bus and store types
	typedef logic [ADDR_W-1:0]         addr_t;
	typedef logic [DATA_W-1:0]         word_t;
	typedef logic [7:0]                byte_t;
	typedef logic [BYTES_PER_WORD-1:0] strb_t;
	typedef logic [TAG_W-1:0]          tag_t;
	typedef logic [INDEX_W-1:0]        index_t;
	typedef logic [WORD_OFS_W-1:0]     beat_t;
	typedef logic [2:0]                hsize_t;
	typedef logic [1:0]                htrans_t;

	// AHB transfer types, BUSY is never issued
	localparam htrans_t HTRANS_IDLE = 2'b00;
	localparam htrans_t HTRANS_NSEQ = 2'b10;
	localparam htrans_t HTRANS_SEQ  = 2'b11;

	// One tag RAM entry
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

	// ------------------------------------------------
	// Controller states
	// BURST states overlap a downstream data phase with the next address phase,
	// LAST states carry the final data phase only
	typedef enum logic [4:0] {
		IDLE,
		READ_CHECK,
		READ_CLEAN_BURST,
		READ_CLEAN_LAST,
		READ_FILL_BURST,
		READ_FILL_LAST,
		READ_DONE,
		WRITE_CHECK,
		WRITE_CLEAN_BURST,
		WRITE_CLEAN_LAST,
		WRITE_FILL_BURST,
		WRITE_FILL_LAST,
		WRITE_MODIFY,
		WRITE_DONE
	} cache_state_t;

endpackage

`default_nettype wire

/* source/cache_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cache_mem_if;

	// Tag port controls
	cache_pkg::addr_t tag_addr;
	logic             tag_ren;
	logic             tag_wen;
	logic             tag_wvalid;
	logic             tag_wdirty;

	// Data port controls
	cache_pkg::addr_t data_addr;
	logic             data_ren;
	cache_pkg::strb_t data_wen;
	cache_pkg::word_t wdata;

	// Results, valid the cycle after a read and held until the next one
	logic             hit;
	logic             dirty;
	cache_pkg::addr_t victim_addr;
	cache_pkg::word_t rdata;

	// Controller side
	modport ctrl (
		output tag_addr, tag_ren, tag_wen, tag_wvalid, tag_wdirty,
		output data_addr, data_ren, data_wen, wdata,
		input  hit, dirty, victim_addr, rdata
	);

	// Store side
	modport store (
		input  tag_addr, tag_ren, tag_wen, tag_wvalid, tag_wdirty,
		input  data_addr, data_ren, data_wen, wdata,
		output hit, dirty, victim_addr, rdata
	);

endinterface

`default_nettype wire

/* source/cache_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sram #(
	parameter type payload     = logic,
	parameter int  DEPTH       = 64,
	parameter bit  CLEAR_VALID = 1'b0
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire [$clog2(DEPTH)-1:0]   addr,
	input  wire                       ren,
	input  wire                       wen,
	input  wire payload               wdata,
	output payload                    rdata
);

	payload           mem [DEPTH];
	logic [DEPTH-1:0] filled;

	// Tag instance tracks written entries so a reset leaves every line invalid
	generate
		if (CLEAR_VALID) begin : g_valid
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					filled <= '0;
				end else if (wen) begin
					filled[addr] <= 1'b1;
				end
			end
		end else begin : g_no_valid
			// Data lanes are only read behind a valid tag
			assign filled = '1;
		end
	endgenerate

	// Registered read, output held while ren is low
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[addr] <= wdata;
		end
		if (ren) begin
			rdata <= filled[addr] ? mem[addr] : payload'(0);
		end
	end

endmodule

`default_nettype wire

/* source/cache_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_store (
	input wire         clk,
	input wire         rst_n,
	cache_mem_if.store mem
);

	localparam int LINE_OFS_W = cache_pkg::WORD_OFS_W + cache_pkg::BYTE_OFS_W;
	localparam int DATA_AW    = cache_pkg::INDEX_W + cache_pkg::WORD_OFS_W;

	cache_pkg::index_t     tag_index;
	logic [DATA_AW-1:0]    data_index;
	cache_pkg::tag_t       req_tag;
	cache_pkg::index_t     req_index;
	cache_pkg::tag_entry_t tag_wentry;
	cache_pkg::tag_entry_t tag_rentry;
	cache_pkg::word_t      lane_rdata;

	// ------------------------------------------------
	// Address decode
	assign tag_index  = mem.tag_addr[LINE_OFS_W +: cache_pkg::INDEX_W];
	assign data_index = mem.data_addr[cache_pkg::BYTE_OFS_W +: DATA_AW];

	// New entry always carries the tag of the current request
	assign tag_wentry = '{
		valid: mem.tag_wvalid,
		dirty: mem.tag_wdirty,
		tag:   mem.tag_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W]
	};

	// Requested tag and index, lined up with the entry read out
	always_ff @(posedge clk) begin
		if (mem.tag_ren) begin
			req_tag   <= mem.tag_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
			req_index <= tag_index;
		end
	end

	// ------------------------------------------------
	// Tag RAM, one entry per line
	cache_sram #(
		.payload     (cache_pkg::tag_entry_t),
		.DEPTH       (cache_pkg::NUM_LINES),
		.CLEAR_VALID (1'b1)
	) u_tag_ram (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (tag_index),
		.ren   (mem.tag_ren),
		.wen   (mem.tag_wen),
		.wdata (tag_wentry),
		.rdata (tag_rentry)
	);

	// Data RAM, one byte lane per instance so writes can merge
	for (genvar i = 0; i < cache_pkg::BYTES_PER_WORD; i++) begin : g_lane
		cache_sram #(
			.payload     (cache_pkg::byte_t),
			.DEPTH       (cache_pkg::NUM_LINES * cache_pkg::LINE_WORDS),
			.CLEAR_VALID (1'b0)
		) u_data_ram (
			.clk   (clk),
			.rst_n (rst_n),
			.addr  (data_index),
			.ren   (mem.data_ren),
			.wen   (mem.data_wen[i]),
			.wdata (mem.wdata[8*i +: 8]),
			.rdata (lane_rdata[8*i +: 8])
		);
	end

	// ------------------------------------------------
	// Lookup results
	assign mem.hit   = tag_rentry.valid && (tag_rentry.tag == req_tag);
	assign mem.dirty = tag_rentry.valid && tag_rentry.dirty;
	assign mem.rdata = lane_rdata;

	// Line base of the resident line, where a write-back goes
	assign mem.victim_addr = {tag_rentry.tag, req_index, {LINE_OFS_W{1'b0}}};

endmodule

`default_nettype wire

/* source/burst_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     dst_hready_resp,
	input  wire cache_pkg::htrans_t dst_htrans,
	input  wire cache_pkg::addr_t   req_addr,
	input  wire cache_pkg::addr_t   victim_addr,
	input  wire                     cleaning,
	output cache_pkg::addr_t        beat_addr,
	output cache_pkg::addr_t        beat_addr_dph,
	output logic                    last_beat,
	output logic                    beat_is_critical
);

	localparam int LINE_OFS_W = cache_pkg::WORD_OFS_W + cache_pkg::BYTE_OFS_W;
	localparam int BASE_W     = cache_pkg::ADDR_W - LINE_OFS_W;

	cache_pkg::beat_t  count;
	cache_pkg::beat_t  prev_count;
	cache_pkg::beat_t  req_beat;
	logic [BASE_W-1:0] req_base;
	logic [BASE_W-1:0] aph_base;
	logic              crit_q;

	assign req_beat = req_addr[cache_pkg::BYTE_OFS_W +: cache_pkg::WORD_OFS_W];
	assign req_base = req_addr[cache_pkg::ADDR_W-1 -: BASE_W];

	// Write-back walks the victim line, fill walks the requested line
	assign aph_base = cleaning ? victim_addr[cache_pkg::ADDR_W-1 -: BASE_W] : req_base;

	// ------------------------------------------------
	// Beat counter
	// Clean and fill run back to back, so the count wraps from the last clean
	// beat straight into the first fill beat
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count  <= '0;
			crit_q <= 1'b0;
		end else if (dst_hready_resp) begin
			if (dst_htrans == cache_pkg::HTRANS_IDLE) begin
				count  <= '0;
				crit_q <= 1'b0;
			end else begin
				count  <= count + 1'b1;
				// Next data phase carries the word the master asked for
				crit_q <= (count == req_beat);
			end
		end
	end

	// Data phase lags the address phase by one beat
	assign prev_count = count - 1'b1;

	assign beat_addr     = {aph_base, count, {cache_pkg::BYTE_OFS_W{1'b0}}};
	assign beat_addr_dph = {req_base, prev_count, {cache_pkg::BYTE_OFS_W{1'b0}}};

	assign last_beat        = &count;
	assign beat_is_critical = crit_q;

endmodule

`default_nettype wire

/* source/cache_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_fsm (
	input  wire                     clk,
	input  wire                     rst_n,
	// Upstream AHB-Lite slave
	input  wire cache_pkg::addr_t   src_haddr,
	input  wire                     src_hwrite,
	input  wire cache_pkg::htrans_t src_htrans,
	input  wire cache_pkg::hsize_t  src_hsize,
	input  wire cache_pkg::word_t   src_hwdata,
	output logic                    src_hready_resp,
	output cache_pkg::word_t        src_hrdata,
	// Downstream AHB-Lite master
	output cache_pkg::addr_t        dst_haddr,
	output cache_pkg::htrans_t      dst_htrans,
	output logic                    dst_hwrite,
	output cache_pkg::word_t        dst_hwdata,
	input  wire                     dst_hready_resp,
	input  wire cache_pkg::word_t   dst_hrdata,
	// Store and burst counter
	cache_mem_if.ctrl               mem,
	input  wire cache_pkg::addr_t   beat_addr,
	input  wire cache_pkg::addr_t   beat_addr_dph,
	input  wire                     last_beat,
	input  wire                     beat_is_critical,
	output cache_pkg::addr_t        req_addr,
	output logic                    cleaning
);

	cache_pkg::cache_state_t state;
	cache_pkg::cache_state_t state_next;
	cache_pkg::cache_state_t accept_next;
	cache_pkg::hsize_t       req_size;
	cache_pkg::word_t        crit_word;
	cache_pkg::strb_t        byte_mask;
	logic                    src_aphase;
	logic                    in_check;
	logic                    in_fill;
	logic                    fill_beat;
	logic                    fill_last;
	logic                    write_hit;
	logic                    modify;

	// ------------------------------------------------
	// Upstream decode
	// NSEQ and SEQ both have bit 1 set
	assign src_aphase  = src_htrans[1] && src_hready_resp;
	assign accept_next = !src_aphase ? cache_pkg::IDLE :
		src_hwrite ? cache_pkg::WRITE_CHECK : cache_pkg::READ_CHECK;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_addr <= '0;
			req_size <= '0;
		end else if (src_aphase) begin
			req_addr <= src_haddr;
			req_size <= src_hsize;
		end
	end

	// State groups
	assign in_check  = (state == cache_pkg::READ_CHECK) || (state == cache_pkg::WRITE_CHECK);
	assign fill_last = (state == cache_pkg::READ_FILL_LAST) ||
		(state == cache_pkg::WRITE_FILL_LAST);
	assign in_fill   = fill_last || (state == cache_pkg::READ_FILL_BURST) ||
		(state == cache_pkg::WRITE_FILL_BURST);
	assign fill_beat = in_fill && dst_hready_resp;
	assign write_hit = (state == cache_pkg::WRITE_CHECK) && mem.hit;
	assign modify    = write_hit || (state == cache_pkg::WRITE_MODIFY);

	// Write-back address phases, dirty miss in CHECK opens the burst
	assign cleaning = (in_check && !mem.hit && mem.dirty) ||
		(state == cache_pkg::READ_CLEAN_BURST) || (state == cache_pkg::WRITE_CLEAN_BURST);

	// ------------------------------------------------
	// State machine
	always_comb begin
		state_next = state;
		case (state)
			cache_pkg::IDLE,
			cache_pkg::READ_DONE,
			cache_pkg::WRITE_DONE: state_next = accept_next;
			cache_pkg::READ_CHECK: begin
				if (mem.hit) begin
					state_next = accept_next;
				end else if (dst_hready_resp) begin
					state_next = mem.dirty ? cache_pkg::READ_CLEAN_BURST :
						cache_pkg::READ_FILL_BURST;
				end
			end
			cache_pkg::READ_CLEAN_BURST: begin
				if (dst_hready_resp && last_beat) state_next = cache_pkg::READ_CLEAN_LAST;
			end
			cache_pkg::READ_CLEAN_LAST: begin
				if (dst_hready_resp) state_next = cache_pkg::READ_FILL_BURST;
			end
			cache_pkg::READ_FILL_BURST: begin
				if (dst_hready_resp && last_beat) state_next = cache_pkg::READ_FILL_LAST;
			end
			cache_pkg::READ_FILL_LAST: begin
				if (dst_hready_resp) state_next = cache_pkg::READ_DONE;
			end
			cache_pkg::WRITE_CHECK: begin
				if (mem.hit) begin
					state_next = cache_pkg::WRITE_DONE;
				end else if (dst_hready_resp) begin
					state_next = mem.dirty ? cache_pkg::WRITE_CLEAN_BURST :
						cache_pkg::WRITE_FILL_BURST;
				end
			end
			cache_pkg::WRITE_CLEAN_BURST: begin
				if (dst_hready_resp && last_beat) state_next = cache_pkg::WRITE_CLEAN_LAST;
			end
			cache_pkg::WRITE_CLEAN_LAST: begin
				if (dst_hready_resp) state_next = cache_pkg::WRITE_FILL_BURST;
			end
			cache_pkg::WRITE_FILL_BURST: begin
				if (dst_hready_resp && last_beat) state_next = cache_pkg::WRITE_FILL_LAST;
			end
			cache_pkg::WRITE_FILL_LAST: begin
				if (dst_hready_resp) state_next = cache_pkg::WRITE_MODIFY;
			end
			// Fresh line is in, merge the pending bytes
			cache_pkg::WRITE_MODIFY: state_next = cache_pkg::WRITE_DONE;
			default: state_next = cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cache_pkg::IDLE;
		end else begin
			state <= state_next;
		end
	end

	// ------------------------------------------------
	// Store steering
	// Byte lanes of the held write
	always_comb begin
		case (req_size)
			3'd0:                 byte_mask = 4'b0001 << req_addr[1:0];
			3'd1:                 byte_mask = 4'b0011 << req_addr[1:0];
			cache_pkg::HSIZE_WORD: byte_mask = 4'b1111;
			default:              byte_mask = 4'b1111;
		endcase
	end

	// Live address only while a new address phase can be taken
	assign mem.tag_addr = src_hready_resp ? src_haddr : req_addr;
	assign mem.tag_ren  = src_aphase;

	// Line is invalid until its last fill beat lands
	assign mem.tag_wen    = write_hit || fill_beat || (state == cache_pkg::WRITE_MODIFY);
	assign mem.tag_wvalid = modify || fill_last;
	assign mem.tag_wdirty = modify;

	assign mem.data_addr = cleaning ? beat_addr :
		in_fill  ? beat_addr_dph :
		modify   ? req_addr : src_haddr;

	// Write-back words are read one beat ahead of their data phase
	assign mem.data_ren = (src_aphase && !src_hwrite) || (cleaning && dst_hready_resp);
	assign mem.data_wen = fill_beat ? 4'b1111 : modify ? byte_mask : 4'b0000;
	assign mem.wdata    = modify ? src_hwdata : dst_hrdata;

	// ------------------------------------------------
	// Downstream request
	always_comb begin
		if ((in_check && !mem.hit) || (state == cache_pkg::READ_CLEAN_LAST) ||
			(state == cache_pkg::WRITE_CLEAN_LAST)) begin
			dst_htrans = cache_pkg::HTRANS_NSEQ;
		end else if ((state == cache_pkg::READ_CLEAN_BURST) ||
			(state == cache_pkg::WRITE_CLEAN_BURST) ||
			(state == cache_pkg::READ_FILL_BURST) ||
			(state == cache_pkg::WRITE_FILL_BURST)) begin
			dst_htrans = cache_pkg::HTRANS_SEQ;
		end else begin
			dst_htrans = cache_pkg::HTRANS_IDLE;
		end
	end

	assign dst_haddr  = beat_addr;
	assign dst_hwrite = cleaning;
	// Store read data holds through wait states
	assign dst_hwdata = mem.rdata;

	// ------------------------------------------------
	// Upstream response
	// Requested word caught on its way into the line
	always_ff @(posedge clk) begin
		if (fill_beat && beat_is_critical) begin
			crit_word <= dst_hrdata;
		end
	end

	assign src_hrdata = (state == cache_pkg::READ_DONE) ? crit_word : mem.rdata;

	assign src_hready_resp = (state == cache_pkg::IDLE) ||
		((state == cache_pkg::READ_CHECK) && mem.hit) ||
		(state == cache_pkg::READ_DONE) ||
		(state == cache_pkg::WRITE_DONE);

endmodule

`default_nettype wire

/* source/ahb_cache_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_cache_wb_top (
	input  wire                     clk,
	input  wire                     rst_n,
	// Upstream AHB-Lite slave
	input  wire cache_pkg::addr_t   src_haddr,
	input  wire                     src_hwrite,
	input  wire cache_pkg::htrans_t src_htrans,
	input  wire cache_pkg::hsize_t  src_hsize,
	input  wire cache_pkg::word_t   src_hwdata,
	output cache_pkg::word_t        src_hrdata,
	output logic                    src_hready_resp,
	// Downstream AHB-Lite master
	output cache_pkg::addr_t        dst_haddr,
	output cache_pkg::htrans_t      dst_htrans,
	output logic                    dst_hwrite,
	output cache_pkg::word_t        dst_hwdata,
	input  wire                     dst_hready_resp,
	input  wire cache_pkg::word_t   dst_hrdata
);

	cache_pkg::addr_t beat_addr;
	cache_pkg::addr_t beat_addr_dph;
	cache_pkg::addr_t req_addr;
	logic             last_beat;
	logic             beat_is_critical;
	logic             cleaning;

	// Controller to store
	cache_mem_if mem_if ();

	// ------------------------------------------------
	// Controller
	cache_fsm u_cache_fsm (
		.clk              (clk),
		.rst_n            (rst_n),
		.src_haddr        (src_haddr),
		.src_hwrite       (src_hwrite),
		.src_htrans       (src_htrans),
		.src_hsize        (src_hsize),
		.src_hwdata       (src_hwdata),
		.src_hready_resp  (src_hready_resp),
		.src_hrdata       (src_hrdata),
		.dst_haddr        (dst_haddr),
		.dst_htrans       (dst_htrans),
		.dst_hwrite       (dst_hwrite),
		.dst_hwdata       (dst_hwdata),
		.dst_hready_resp  (dst_hready_resp),
		.dst_hrdata       (dst_hrdata),
		.mem              (mem_if.ctrl),
		.beat_addr        (beat_addr),
		.beat_addr_dph    (beat_addr_dph),
		.last_beat        (last_beat),
		.beat_is_critical (beat_is_critical),
		.req_addr         (req_addr),
		.cleaning         (cleaning)
	);

	// Line burst beats
	burst_addr_gen u_burst_addr_gen (
		.clk              (clk),
		.rst_n            (rst_n),
		.dst_hready_resp  (dst_hready_resp),
		.dst_htrans       (dst_htrans),
		.req_addr         (req_addr),
		.victim_addr      (mem_if.victim_addr),
		.cleaning         (cleaning),
		.beat_addr        (beat_addr),
		.beat_addr_dph    (beat_addr_dph),
		.last_beat        (last_beat),
		.beat_is_critical (beat_is_critical)
	);

	// Tag and data RAMs
	cache_store u_cache_store (
		.clk   (clk),
		.rst_n (rst_n),
		.mem   (mem_if.store)
	);

endmodule

`default_nettype wire

/* test/cache_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sva (
	input wire                          clk,
	input wire                          rst_n,
	input wire cache_pkg::htrans_t      src_htrans,
	input wire cache_pkg::htrans_t      dst_htrans,
	input wire cache_pkg::addr_t        dst_haddr,
	input wire                          dst_hready_resp,
	input wire                          src_hready_resp,
	input wire cache_pkg::cache_state_t state
);

	// ------------------------------------------------
	// Downstream burst rules
	// A SEQ beat only continues a burst
	a_seq_after_burst: assert property (@(posedge clk) disable iff (!rst_n)
		(dst_htrans == cache_pkg::HTRANS_SEQ) |->
		(($past(dst_htrans) == cache_pkg::HTRANS_NSEQ) ||
		($past(dst_htrans) == cache_pkg::HTRANS_SEQ)))
		else $error("SEQ without a preceding NSEQ or SEQ");

	// Pending transfer held through wait states
	a_hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
		(!dst_hready_resp && (dst_htrans != cache_pkg::HTRANS_IDLE)) |=>
		($stable(dst_haddr) && $stable(dst_htrans)))
		else $error("Downstream address phase changed during a wait state");

	// A ready cycle with no request leaves the controller idle and ready
	a_ready_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(src_hready_resp && !src_htrans[1]) |=>
		((state == cache_pkg::IDLE) && src_hready_resp))
		else $error("Controller not idle and ready after a cycle without a request");

endmodule

bind cache_fsm cache_sva u_cache_sva (.*);

`default_nettype wire

/* test/tb_ahb_cache_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_cache_wb;

	logic               clk;
	logic               rst_n;
	cache_pkg::addr_t   src_haddr;
	logic               src_hwrite;
	cache_pkg::htrans_t src_htrans;
	cache_pkg::hsize_t  src_hsize;
	cache_pkg::word_t   src_hwdata;
	cache_pkg::word_t   src_hrdata;
	logic               src_hready_resp;
	cache_pkg::addr_t   dst_haddr;
	cache_pkg::htrans_t dst_htrans;
	logic               dst_hwrite;
	cache_pkg::word_t   dst_hwdata;
	logic               dst_hready_resp;
	cache_pkg::word_t   dst_hrdata;

	integer seed = 32'h1d26_aecb;
	integer errors = 0;
	logic   waits_on = 1'b0;
	logic   timed_out = 1'b0;

	// Downstream memory and the log of accepted address phases
	cache_pkg::word_t   mem_model [cache_pkg::addr_t];
	logic               dph_valid;
	logic               dph_write;
	cache_pkg::addr_t   dph_addr;
	cache_pkg::addr_t   log_addr [$];
	cache_pkg::htrans_t log_trans [$];
	logic               log_write [$];

	// Line base resident at each index, where a write-back must go
	cache_pkg::addr_t   resident [cache_pkg::index_t];

	ahb_cache_wb_top u_ahb_cache_wb_top (.*);

	// ------------------------------------------------
	// Clock, 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Unwritten words follow the address pattern
	function automatic cache_pkg::word_t mem_read(input cache_pkg::addr_t addr);
		if (mem_model.exists(addr)) return mem_model[addr];
		return addr ^ 32'h5a5a_0000;
	endfunction

	// Index and base of the line holding an address
	function automatic cache_pkg::index_t line_index(input cache_pkg::addr_t addr);
		return addr[9:4];
	endfunction

	function automatic cache_pkg::addr_t line_base(input cache_pkg::addr_t addr);
		return {addr[31:4], 4'h0};
	endfunction

	// Bus sampled mid-cycle, the cycle ends in a transfer when ready is high
	always @(negedge clk) begin
		if (!rst_n) begin
			dph_valid = 1'b0;
		end else if (dst_hready_resp) begin
			if (dph_valid && dph_write) mem_model[dph_addr] = dst_hwdata;
			dph_valid = dst_htrans[1];
			dph_addr  = dst_haddr;
			dph_write = dst_hwrite;
			if (dst_htrans[1]) begin
				log_addr.push_back(dst_haddr);
				log_trans.push_back(dst_htrans);
				log_write.push_back(dst_hwrite);
			end
		end
	end

	// Response for the data phase in flight, random wait states when enabled
	always @(posedge clk) begin
		#1;
		dst_hready_resp = (!rst_n || !waits_on) ? 1'b1 : $random(seed) & 1;
		dst_hrdata = (dph_valid && !dph_write) ? mem_read(dph_addr) : '0;
	end

	// ------------------------------------------------
	// Compare tasks
	task automatic check_word(input cache_pkg::word_t actual, input cache_pkg::word_t expected,
		input string name);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_trans(input cache_pkg::htrans_t actual,
		input cache_pkg::htrans_t expected, input string name);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string name);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
			errors++;
		end
	endtask

	// Waits up to 200 cycles for the upstream ready, sampled mid-cycle
	task automatic wait_ready();
		integer n;
		n = 0;
		@(negedge clk);
		while (!src_hready_resp && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (!src_hready_resp) begin
			$display("Timeout: upstream ready stayed low for 200 cycles");
			errors++;
			timed_out = 1'b1;
		end
	endtask

	// Write-back group first, then the fill of the requested line
	task automatic check_bursts(input cache_pkg::addr_t addr, input integer beats);
		cache_pkg::addr_t base;
		cache_pkg::addr_t victim;
		victim = resident.exists(line_index(addr)) ? resident[line_index(addr)] : '0;
		if (log_addr.size() != beats) begin
			$display("Downstream issued %0d beats for address %h, expected %0d",
				log_addr.size(), addr, beats);
			errors++;
		end else begin
			for (int k = 0; k < beats; k++) begin
				base = (beats == 8 && k < 4) ? victim : line_base(addr);
				check_trans(log_trans[k], (k % 4 == 0) ? cache_pkg::HTRANS_NSEQ :
					cache_pkg::HTRANS_SEQ, "dst_htrans");
				check_word(log_addr[k], base + 4 * (k % 4), "dst_haddr");
				check_bit(log_write[k], (beats == 8 && k < 4), "dst_hwrite");
			end
		end
	endtask

	// One upstream transfer, data phase held until ready
	task automatic run_transfer(input byte op, input cache_pkg::addr_t addr,
		input cache_pkg::hsize_t size, input cache_pkg::word_t wdata,
		input cache_pkg::word_t expected, input integer beats);
		log_addr.delete();
		log_trans.delete();
		log_write.delete();
		src_haddr  = addr;
		src_hwrite = (op == "W");
		src_hsize  = size;
		src_htrans = cache_pkg::HTRANS_NSEQ;
		wait_ready();
		if (timed_out) return;
		@(posedge clk);
		#1;
		src_htrans = cache_pkg::HTRANS_IDLE;
		src_hwdata = wdata;
		wait_ready();
		if (timed_out) return;
		if (op == "R") check_word(src_hrdata, expected, "src_hrdata");
		@(posedge clk);
		#1;
		check_bursts(addr, beats);
		// Requested line now occupies its index
		resident[line_index(addr)] = line_base(addr);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		mem_model.delete();
		resident.delete();
	endtask

	// Reads the case list, one transfer per line
	task automatic run_cases();
		integer fd;
		integer n;
		string  line;
		byte    op;
		cache_pkg::addr_t  addr;
		cache_pkg::hsize_t size;
		cache_pkg::word_t  wdata;
		cache_pkg::word_t  expected;
		integer            beats;
		fd = $fopen("test/cache_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/cache_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h %h %h %d", op, addr, size, wdata,
						expected, beats);
					if (n == 6) run_transfer(op, addr, size, wdata, expected, beats);
				end
			end
			$fclose(fd);
		end
	endtask

	// ------------------------------------------------
	// Main sequence
	initial begin
		rst_n           = 1'b0;
		src_haddr       = '0;
		src_hwrite      = 1'b0;
		src_htrans      = cache_pkg::HTRANS_IDLE;
		src_hsize       = cache_pkg::HSIZE_WORD;
		src_hwdata      = '0;
		dst_hready_resp = 1'b1;
		dst_hrdata      = '0;

		// Zero wait states first, then the same list with random stalls
		apply_reset();
		run_cases();
		waits_on = 1'b1;
		apply_reset();
		run_cases();

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
source/cache_pkg.sv
source/cache_mem_if.sv
source/cache_sram.sv
source/cache_store.sv
source/burst_addr_gen.sv
source/cache_fsm.sv
source/ahb_cache_wb_top.sv
test/cache_sva.sv
test/tb_ahb_cache_wb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ahb_cache_wb -f project.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

/* test/cache_cases.txt */
# op addr size wdata expected_rdata downstream_beats
# op R or W, hex fields, beats in decimal (4 = fill, 8 = write-back plus fill)
R 00001044 2 00000000 5a5a1044 4
R 00001040 2 00000000 5a5a1040 0
R 0000104c 2 00000000 5a5a104c 0
W 00001041 0 0000ab00 00000000 0
W 00001046 1 cdef0000 00000000 0
R 00001040 2 00000000 5a5aab40 0
R 00001044 2 00000000 cdef1044 0
W 00001048 2 12345678 00000000 0
R 00002044 2 00000000 5a5a2044 8
R 00001040 2 00000000 5a5aab40 4
R 00001048 2 00000000 12345678 0
R 00001044 2 00000000 cdef1044 0
W 00003083 0 77000000 00000000 4
R 00003080 2 00000000 775a3080 0
R 00003084 2 00000000 5a5a3084 0
